/* include/link_params.svh */
`ifndef LINK_PARAMS_SVH
`define LINK_PARAMS_SVH

// payload of one message, 9 bytes
`define MESSAGE_BIT 72

// message length in bytes, fits the low bits of a header byte
`define LENGTH_BIT 5

// channel select bits, 2 channels
`define CHANNEL_BIT 1

// clock cycles per serial bit, short for simulation
`define CLKS_PER_BIT 8

`endif

/* source/link_pkg.sv */
package link_pkg;

	// serial byte engine, shared by transmit and receive
	typedef enum logic [1:0] {
		UART_IDLE,
		UART_START,
		UART_DATA,
		UART_STOP
	} uart_state_t;

	// framing engine, used by both directions
	// header  waiting for or sending the header byte
	// payload moving message bytes, lsb first
	// done    one cycle to hand off or deliver the frame
	typedef enum logic [1:0] {
		FRAME_HEADER,
		FRAME_PAYLOAD,
		FRAME_DONE
	} frame_state_t;

endpackage

/* source/mem_pkg.sv */
package mem_pkg;

	// request code held on each memory port
	typedef enum logic [1:0] {
		REQ_NONE  = 2'd0,
		REQ_READ  = 2'd1,
		REQ_WRITE = 2'd2
	} mem_req_t;

	// opcode in the high nibble of byte 0 of a host message
	typedef enum logic [3:0] {
		OP_READ  = 4'd1,
		OP_WRITE = 4'd2,
		OP_ACK   = 4'd3
	} mem_op_t;

	// memory controller sequence
	typedef enum logic [1:0] {
		CTRL_IDLE,
		CTRL_SEND,
		CTRL_WAIT_REPLY,
		CTRL_FINISH
	} ctrl_state_t;

endpackage

/* source/uart_comm.sv */
`timescale 1ns/100ps
`include "link_params.svh"

module uart_comm #(
	parameter int CLKS_PER_BIT = `CLKS_PER_BIT
) (
	input  logic       clk,
	input  logic       button,
	input  logic       send_flag,
	input  logic [7:0] send_data,
	output logic       recv_flag,
	output logic [7:0] recv_data,
	output logic       sendable,
	output logic       tx,
	input  logic       rx
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
	localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLKS_PER_BIT / 2 - 1);

	link_pkg::uart_state_t tx_state;
	logic [CNT_W-1:0] tx_cnt;
	logic [2:0] tx_bit;
	logic [7:0] tx_shift;

	link_pkg::uart_state_t rx_state;
	logic [CNT_W-1:0] rx_cnt;
	logic [2:0] rx_bit;
	logic [7:0] rx_shift;
	logic rx_meta;
	logic rx_sync;

	// transmitter
	always_ff @(posedge clk or negedge button)
	begin
		if (!button)
		begin
			tx_state <= link_pkg::UART_IDLE;
			tx_cnt <= '0;
			tx_bit <= '0;
		end
		else
		begin
			case (tx_state)
				link_pkg::UART_IDLE:
				begin
					if (send_flag)
					begin
						tx_state <= link_pkg::UART_START;
						tx_cnt <= '0;
					end
				end
				link_pkg::UART_START:
				begin
					if (tx_cnt == BIT_END)
					begin
						tx_cnt <= '0;
						tx_bit <= '0;
						tx_state <= link_pkg::UART_DATA;
					end
					else
						tx_cnt <= tx_cnt + 1'b1;
				end
				link_pkg::UART_DATA:
				begin
					if (tx_cnt == BIT_END)
					begin
						tx_cnt <= '0;
						tx_bit <= tx_bit + 1'b1;
						if (tx_bit == 3'd7)
							tx_state <= link_pkg::UART_STOP;
					end
					else
						tx_cnt <= tx_cnt + 1'b1;
				end
				default:
				begin
					// stop bit, sendable again once it ends
					if (tx_cnt == BIT_END)
						tx_state <= link_pkg::UART_IDLE;
					else
						tx_cnt <= tx_cnt + 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (tx_state == link_pkg::UART_IDLE && send_flag)
			tx_shift <= send_data;
		else if (tx_state == link_pkg::UART_DATA && tx_cnt == BIT_END)
			tx_shift <= tx_shift >> 1;
	end

	always_comb
	begin
		case (tx_state)
			link_pkg::UART_START: tx = 1'b0;
			link_pkg::UART_DATA:  tx = tx_shift[0];
			default:              tx = 1'b1;
		endcase
	end

	assign sendable = (tx_state == link_pkg::UART_IDLE);

	// receiver, rx is asynchronous to clk
	always_ff @(posedge clk or negedge button)
	begin
		if (!button)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk or negedge button)
	begin
		if (!button)
		begin
			rx_state <= link_pkg::UART_IDLE;
			rx_cnt <= '0;
			rx_bit <= '0;
			recv_flag <= 1'b0;
		end
		else
		begin
			recv_flag <= 1'b0;
			case (rx_state)
				link_pkg::UART_IDLE:
				begin
					rx_cnt <= '0;
					if (!rx_sync)
						rx_state <= link_pkg::UART_START;
				end
				link_pkg::UART_START:
				begin
					// recheck at mid start bit, glitches fall back to idle
					if (rx_cnt == HALF_END)
					begin
						rx_cnt <= '0;
						rx_bit <= '0;
						if (!rx_sync)
							rx_state <= link_pkg::UART_DATA;
						else
							rx_state <= link_pkg::UART_IDLE;
					end
					else
						rx_cnt <= rx_cnt + 1'b1;
				end
				link_pkg::UART_DATA:
				begin
					if (rx_cnt == BIT_END)
					begin
						rx_cnt <= '0;
						rx_bit <= rx_bit + 1'b1;
						if (rx_bit == 3'd7)
							rx_state <= link_pkg::UART_STOP;
					end
					else
						rx_cnt <= rx_cnt + 1'b1;
				end
				default:
				begin
					if (rx_cnt == BIT_END)
					begin
						recv_flag <= rx_sync;
						rx_state <= link_pkg::UART_IDLE;
					end
					else
						rx_cnt <= rx_cnt + 1'b1;
				end
			endcase
		end
	end

	// lsb arrives first
	always_ff @(posedge clk)
	begin
		if (rx_state == link_pkg::UART_DATA && rx_cnt == BIT_END)
			rx_shift <= {rx_sync, rx_shift[7:1]};
	end

	assign recv_data = rx_shift;

	a_send_when_sendable: assert property (
		@(posedge clk) disable iff (!button) send_flag |-> sendable
	);

endmodule

/* source/multchan_comm.sv */
`timescale 1ns/100ps
`include "link_params.svh"

module multchan_comm #(
	parameter int MESSAGE_BIT = `MESSAGE_BIT,
	parameter int CHANNEL_BIT = `CHANNEL_BIT
) (
	input  logic                                         clk,
	input  logic                                         button,
	output logic                                         send_flag,
	output logic [7:0]                                   send_data,
	input  logic                                         recv_flag,
	input  logic [7:0]                                   recv_data,
	input  logic                                         sendable,
	output logic [(1<<CHANNEL_BIT)-1:0]                  r_flag,
	output logic [(1<<CHANNEL_BIT)*MESSAGE_BIT-1:0]      r_data,
	output logic [(1<<CHANNEL_BIT)*`LENGTH_BIT-1:0]      r_length,
	input  logic [(1<<CHANNEL_BIT)-1:0]                  w_flag,
	input  logic [(1<<CHANNEL_BIT)*MESSAGE_BIT-1:0]      w_data,
	input  logic [(1<<CHANNEL_BIT)*`LENGTH_BIT-1:0]      w_length,
	output logic [(1<<CHANNEL_BIT)-1:0]                  readable,
	output logic [(1<<CHANNEL_BIT)-1:0]                  writable
);

	localparam int CHANNELS = 1 << CHANNEL_BIT;
	localparam int LEN_W = `LENGTH_BIT;
	localparam int HDR_CHAN_W = 8 - LEN_W;
	localparam int BYTES = MESSAGE_BIT / 8;

	link_pkg::frame_state_t rx_state;
	logic [HDR_CHAN_W-1:0] rx_chan;
	logic [LEN_W-1:0] rx_len;
	logic [LEN_W-1:0] rx_idx;
	logic [MESSAGE_BIT-1:0] rx_buf;

	link_pkg::frame_state_t tx_state;
	logic [CHANNELS-1:0] pend;
	logic [MESSAGE_BIT-1:0] pend_data [CHANNELS];
	logic [LEN_W-1:0] pend_len [CHANNELS];
	logic [CHANNEL_BIT-1:0] tx_sel;
	logic [CHANNEL_BIT-1:0] tx_chan;
	logic [LEN_W-1:0] tx_idx;
	logic tx_go;

	// receive path: header, payload bytes, then deliver
	always_ff @(posedge clk or negedge button)
	begin
		if (!button)
		begin
			rx_state <= link_pkg::FRAME_HEADER;
			rx_chan <= '0;
			rx_len <= '0;
			rx_idx <= '0;
			r_flag <= '0;
		end
		else
		begin
			r_flag <= '0;
			case (rx_state)
				link_pkg::FRAME_HEADER:
				begin
					if (recv_flag)
					begin
						rx_chan <= recv_data[7:LEN_W];
						rx_len <= recv_data[LEN_W-1:0];
						rx_idx <= '0;
						if (recv_data[LEN_W-1:0] == '0)
							rx_state <= link_pkg::FRAME_DONE;
						else
							rx_state <= link_pkg::FRAME_PAYLOAD;
					end
				end
				link_pkg::FRAME_PAYLOAD:
				begin
					if (recv_flag)
					begin
						rx_idx <= rx_idx + 1'b1;
						if (rx_idx == rx_len - 1'b1)
							rx_state <= link_pkg::FRAME_DONE;
					end
				end
				default:
				begin
					// frames for channels that do not exist are dropped
					if (rx_chan < HDR_CHAN_W'(CHANNELS))
						r_flag[rx_chan[CHANNEL_BIT-1:0]] <= 1'b1;
					rx_state <= link_pkg::FRAME_HEADER;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rx_state == link_pkg::FRAME_HEADER && recv_flag)
			rx_buf <= '0;
		else if (rx_state == link_pkg::FRAME_PAYLOAD && recv_flag && rx_idx < LEN_W'(BYTES))
			rx_buf[rx_idx*8 +: 8] <= recv_data;
	end

	// one receive buffer serves all channels, r_flag says whose it is
	assign r_data = {CHANNELS{rx_buf}};
	assign r_length = {CHANNELS{rx_len}};
	assign readable = '1;

	// transmit path
	assign writable = ~pend;
	assign tx_go = sendable && !send_flag;

	// lowest pending channel wins
	always_comb
	begin
		tx_sel = '0;
		for (int c = CHANNELS - 1; c >= 0; c--)
		begin
			if (pend[c])
				tx_sel = CHANNEL_BIT'(c);
		end
	end

	always_ff @(posedge clk)
	begin
		for (int c = 0; c < CHANNELS; c++)
		begin
			if (w_flag[c] && writable[c])
			begin
				pend_data[c] <= w_data[c*MESSAGE_BIT +: MESSAGE_BIT];
				pend_len[c] <= w_length[c*LEN_W +: LEN_W];
			end
		end
	end

	always_ff @(posedge clk or negedge button)
	begin
		if (!button)
		begin
			tx_state <= link_pkg::FRAME_HEADER;
			pend <= '0;
			tx_chan <= '0;
			tx_idx <= '0;
			send_flag <= 1'b0;
		end
		else
		begin
			send_flag <= 1'b0;
			pend <= pend | (w_flag & writable);
			case (tx_state)
				link_pkg::FRAME_HEADER:
				begin
					if (|pend && tx_go)
					begin
						tx_chan <= tx_sel;
						tx_idx <= '0;
						send_flag <= 1'b1;
						if (pend_len[tx_sel] == '0)
						begin
							pend[tx_sel] <= 1'b0;
							tx_state <= link_pkg::FRAME_DONE;
						end
						else
							tx_state <= link_pkg::FRAME_PAYLOAD;
					end
				end
				link_pkg::FRAME_PAYLOAD:
				begin
					if (tx_go)
					begin
						send_flag <= 1'b1;
						tx_idx <= tx_idx + 1'b1;
						// channel frees up as its last byte goes out
						if (tx_idx == pend_len[tx_chan] - 1'b1)
						begin
							pend[tx_chan] <= 1'b0;
							tx_state <= link_pkg::FRAME_DONE;
						end
					end
				end
				default:
					tx_state <= link_pkg::FRAME_HEADER;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (tx_state == link_pkg::FRAME_HEADER && |pend && tx_go)
			send_data <= {HDR_CHAN_W'(tx_sel), pend_len[tx_sel]};
		else if (tx_state == link_pkg::FRAME_PAYLOAD && tx_go)
			send_data <= pend_data[tx_chan][tx_idx*8 +: 8];
	end

	a_write_when_writable: assert property (
		@(posedge clk) disable iff (!button) (w_flag & ~writable) == '0
	);

endmodule

/* source/memory_controller.sv */
`timescale 1ns/100ps
`include "link_params.svh"

module memory_controller (
	input  logic                                  clk,
	input  logic                                  button,
	output logic                                  w_flag,
	output logic [`MESSAGE_BIT-1:0]               w_data,
	output logic [`LENGTH_BIT-1:0]                w_length,
	input  logic                                  r_flag,
	input  logic [`MESSAGE_BIT-1:0]               r_data,
	input  logic [`LENGTH_BIT-1:0]                r_length,
	input  logic                                  writable,
	input  logic                                  readable,
	input  logic [2*$bits(mem_pkg::mem_req_t)-1:0] mem_rw_flag,
	input  logic [63:0]                           mem_addr,
	output logic [63:0]                           mem_r_data,
	input  logic [63:0]                           mem_w_data,
	input  logic [7:0]                            mem_w_mask,
	output logic [1:0]                            mem_busy,
	output logic [1:0]                            mem_done
);

	localparam int REQ_W = $bits(mem_pkg::mem_req_t);
	localparam int LEN_W = `LENGTH_BIT;

	mem_pkg::ctrl_state_t state;
	mem_pkg::mem_req_t req0;
	mem_pkg::mem_req_t req1;
	mem_pkg::mem_req_t pick_req;
	mem_pkg::mem_op_t pick_op;
	logic pick_valid;
	logic pick_port;
	logic accept;
	logic cur_port;
	logic cur_write;
	logic reply_ok;
	logic [31:0] rd_data;

	// port 0 first
	always_comb
	begin
		req0 = mem_pkg::mem_req_t'(mem_rw_flag[REQ_W-1:0]);
		req1 = mem_pkg::mem_req_t'(mem_rw_flag[2*REQ_W-1:REQ_W]);
		pick_valid = 1'b1;
		pick_port = 1'b0;
		pick_req = req0;
		if (req0 == mem_pkg::REQ_NONE)
		begin
			pick_port = 1'b1;
			pick_req = req1;
			pick_valid = (req1 != mem_pkg::REQ_NONE);
		end
		if (pick_req == mem_pkg::REQ_WRITE)
			pick_op = mem_pkg::OP_WRITE;
		else
			pick_op = mem_pkg::OP_READ;
	end

	// the done cycle still sees the old request level, so skip it
	assign accept = (state == mem_pkg::CTRL_IDLE) && pick_valid && (mem_done == 2'b00);

	// read replies carry 4 data bytes, write replies a single ack byte
	always_comb
	begin
		if (cur_write)
			reply_ok = (r_length == LEN_W'(1)) && (r_data[7:4] == mem_pkg::OP_ACK);
		else
			reply_ok = (r_length == LEN_W'(4));
	end

	always_ff @(posedge clk or negedge button)
	begin
		if (!button)
		begin
			state <= mem_pkg::CTRL_IDLE;
			cur_port <= 1'b0;
			cur_write <= 1'b0;
			w_flag <= 1'b0;
			mem_busy <= 2'b00;
			mem_done <= 2'b00;
		end
		else
		begin
			w_flag <= 1'b0;
			mem_done <= 2'b00;
			case (state)
				mem_pkg::CTRL_IDLE:
				begin
					if (mem_done != 2'b00)
						mem_busy <= 2'b00;
					else if (accept)
					begin
						cur_port <= pick_port;
						cur_write <= (pick_req == mem_pkg::REQ_WRITE);
						mem_busy[pick_port] <= 1'b1;
						state <= mem_pkg::CTRL_SEND;
					end
				end
				mem_pkg::CTRL_SEND:
				begin
					if (writable)
					begin
						w_flag <= 1'b1;
						state <= mem_pkg::CTRL_WAIT_REPLY;
					end
				end
				mem_pkg::CTRL_WAIT_REPLY:
				begin
					if (r_flag && reply_ok)
						state <= mem_pkg::CTRL_FINISH;
				end
				default:
				begin
					mem_done[cur_port] <= 1'b1;
					state <= mem_pkg::CTRL_IDLE;
				end
			endcase
		end
	end

	// byte 0 is opcode and mask, then address, then write data
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			w_data <= {mem_w_data[32*pick_port +: 32], mem_addr[32*pick_port +: 32],
				pick_op, mem_w_mask[4*pick_port +: 4]};
			if (pick_req == mem_pkg::REQ_WRITE)
				w_length <= LEN_W'(9);
			else
				w_length <= LEN_W'(5);
		end
		if (state == mem_pkg::CTRL_WAIT_REPLY && r_flag && reply_ok && !cur_write)
			rd_data <= r_data[31:0];
	end

	// only the port under done looks at its half
	assign mem_r_data = {rd_data, rd_data};

	a_done_while_busy: assert property (
		@(posedge clk) disable iff (!button) (mem_done & ~mem_busy) == 2'b00
	);

	a_one_port_busy: assert property (
		@(posedge clk) disable iff (!button) !(&mem_busy)
	);

	a_reply_readable: assert property (
		@(posedge clk) disable iff (!button) r_flag |-> readable
	);

endmodule

/* source/link_top.sv */
`timescale 1ns/100ps
`include "link_params.svh"

module link_top (
	input  logic                                   clk,
	input  logic                                   button,
	output wire                                    tx,
	input  logic                                   rx,
	input  logic [2*$bits(mem_pkg::mem_req_t)-1:0] mem_rw_flag,
	input  logic [63:0]                            mem_addr,
	output wire  [63:0]                            mem_r_data,
	input  logic [63:0]                            mem_w_data,
	input  logic [7:0]                             mem_w_mask,
	output wire  [1:0]                             mem_busy,
	output wire  [1:0]                             mem_done,
	output wire                                    aux_r_flag,
	output wire  [`MESSAGE_BIT-1:0]                aux_r_data,
	output wire  [`LENGTH_BIT-1:0]                 aux_r_length,
	input  logic                                   aux_w_flag,
	input  logic [`MESSAGE_BIT-1:0]                aux_w_data,
	input  logic [`LENGTH_BIT-1:0]                 aux_w_length,
	output wire                                    aux_writable
);

	wire uart_send_flag;
	wire [7:0] uart_send_data;
	wire uart_recv_flag;
	wire [7:0] uart_recv_data;
	wire uart_sendable;

	// channel 0 belongs to the memory controller
	wire ctrl_w_flag;
	wire [`MESSAGE_BIT-1:0] ctrl_w_data;
	wire [`LENGTH_BIT-1:0] ctrl_w_length;
	wire ctrl_r_flag;
	wire [`MESSAGE_BIT-1:0] ctrl_r_data;
	wire [`LENGTH_BIT-1:0] ctrl_r_length;
	wire ctrl_writable;
	wire [1:0] comm_readable;

	uart_comm #(.CLKS_PER_BIT(`CLKS_PER_BIT)) uart (
		.clk(clk), .button(button),
		.send_flag(uart_send_flag), .send_data(uart_send_data),
		.recv_flag(uart_recv_flag), .recv_data(uart_recv_data),
		.sendable(uart_sendable), .tx(tx), .rx(rx)
	);

	multchan_comm #(.MESSAGE_BIT(`MESSAGE_BIT), .CHANNEL_BIT(`CHANNEL_BIT)) comm (
		.clk(clk), .button(button),
		.send_flag(uart_send_flag), .send_data(uart_send_data),
		.recv_flag(uart_recv_flag), .recv_data(uart_recv_data),
		.sendable(uart_sendable),
		.r_flag({aux_r_flag, ctrl_r_flag}),
		.r_data({aux_r_data, ctrl_r_data}),
		.r_length({aux_r_length, ctrl_r_length}),
		.w_flag({aux_w_flag, ctrl_w_flag}),
		.w_data({aux_w_data, ctrl_w_data}),
		.w_length({aux_w_length, ctrl_w_length}),
		.readable(comm_readable),
		.writable({aux_writable, ctrl_writable})
	);

	memory_controller mem_ctrl (
		.clk(clk), .button(button),
		.w_flag(ctrl_w_flag), .w_data(ctrl_w_data), .w_length(ctrl_w_length),
		.r_flag(ctrl_r_flag), .r_data(ctrl_r_data), .r_length(ctrl_r_length),
		.writable(ctrl_writable), .readable(comm_readable[0]),
		.mem_rw_flag(mem_rw_flag), .mem_addr(mem_addr),
		.mem_r_data(mem_r_data), .mem_w_data(mem_w_data), .mem_w_mask(mem_w_mask),
		.mem_busy(mem_busy), .mem_done(mem_done)
	);

endmodule

/* sim/link_tb.sv */
`timescale 1ns/100ps
`include "link_params.svh"

module link_tb;

	localparam int NUM = 16;
	localparam int BIT_CYCLES = `CLKS_PER_BIT;
	localparam int DONE_LIMIT = 4000;
	localparam int BYTE_LIMIT = 16 * `CLKS_PER_BIT;
	localparam int IDLE_LIMIT = 200000;

	logic clk;
	logic button;
	logic rx;
	wire tx;
	logic [2*$bits(mem_pkg::mem_req_t)-1:0] mem_rw_flag;
	logic [63:0] mem_addr;
	wire [63:0] mem_r_data;
	logic [63:0] mem_w_data;
	logic [7:0] mem_w_mask;
	wire [1:0] mem_busy;
	wire [1:0] mem_done;
	wire aux_r_flag;
	wire [`MESSAGE_BIT-1:0] aux_r_data;
	wire [`LENGTH_BIT-1:0] aux_r_length;
	logic aux_w_flag;
	logic [`MESSAGE_BIT-1:0] aux_w_data;
	logic [`LENGTH_BIT-1:0] aux_w_length;
	wire aux_writable;

	// stimulus table with expected read data
	// a pair entry starts in the same cycle as the next one
	int t_port [NUM];
	mem_pkg::mem_req_t t_req [NUM];
	logic [31:0] t_addr [NUM];
	logic [31:0] t_data [NUM];
	logic [3:0] t_mask [NUM];
	logic [31:0] t_expect [NUM];
	logic t_pair [NUM];
	int t_count;

	logic [31:0] exp_mem [logic [31:0]];
	logic [31:0] host_mem [logic [31:0]];
	logic [`MESSAGE_BIT-1:0] host_aux_data [$];
	int host_aux_len [$];

	int n_checks;
	int n_fail;
	int n_timeout;
	logic [1:0] busy_prev;
	int done_order [$];
	int aux_pulses;
	logic [`MESSAGE_BIT-1:0] aux_seen_data;
	logic [`LENGTH_BIT-1:0] aux_seen_len;

	link_top UUT (
		.clk(clk), .button(button), .tx(tx), .rx(rx),
		.mem_rw_flag(mem_rw_flag), .mem_addr(mem_addr), .mem_r_data(mem_r_data),
		.mem_w_data(mem_w_data), .mem_w_mask(mem_w_mask),
		.mem_busy(mem_busy), .mem_done(mem_done),
		.aux_r_flag(aux_r_flag), .aux_r_data(aux_r_data), .aux_r_length(aux_r_length),
		.aux_w_flag(aux_w_flag), .aux_w_data(aux_w_data), .aux_w_length(aux_w_length),
		.aux_writable(aux_writable)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// memory content before any write
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ 32'h6b1d_c3a5;
	endfunction

	// set mask bits take the new byte
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] mask);
		logic [31:0] result;
		result = old_word;
		for (int b = 0; b < 4; b++)
		begin
			if (mask[b])
				result[b*8 +: 8] = new_word[b*8 +: 8];
		end
		return result;
	endfunction

	function automatic logic [`MESSAGE_BIT-1:0] keep_bytes(
		input logic [`MESSAGE_BIT-1:0] data, input logic [`LENGTH_BIT-1:0] len);
		logic [`MESSAGE_BIT-1:0] result;
		result = data;
		for (int b = 0; b < `MESSAGE_BIT / 8; b++)
		begin
			if (b >= int'(len))
				result[b*8 +: 8] = 8'h00;
		end
		return result;
	endfunction

	task automatic add_entry(input int port, input mem_pkg::mem_req_t req,
		input logic [31:0] addr, input logic [31:0] data, input logic [3:0] mask,
		input logic pair);
		logic [31:0] old_word;
		old_word = exp_mem.exists(addr) ? exp_mem[addr] : fill_word(addr);
		t_port[t_count] = port;
		t_req[t_count] = req;
		t_addr[t_count] = addr;
		t_data[t_count] = data;
		t_mask[t_count] = mask;
		t_pair[t_count] = pair;
		t_expect[t_count] = old_word;
		if (req == mem_pkg::REQ_WRITE)
			exp_mem[addr] = merge_bytes(old_word, data, mask);
		t_count++;
	endtask

	task automatic build_table();
		logic [31:0] a0;
		logic [31:0] a1;
		logic [31:0] a2;
		a0 = 32'h0000_1000;
		a1 = 32'h8000_0040;
		a2 = $urandom & 32'hffff_fffc;
		t_count = 0;
		add_entry(0, mem_pkg::REQ_WRITE, a0, $urandom, 4'hf, 1'b0);
		add_entry(0, mem_pkg::REQ_READ, a0, 32'h0, 4'h0, 1'b0);
		add_entry(1, mem_pkg::REQ_WRITE, a1, $urandom, 4'hf, 1'b0);
		add_entry(1, mem_pkg::REQ_READ, a1, 32'h0, 4'h0, 1'b0);
		// partial masks keep the old bytes
		add_entry(0, mem_pkg::REQ_WRITE, a0, $urandom, 4'b0101, 1'b0);
		add_entry(0, mem_pkg::REQ_READ, a0, 32'h0, 4'h0, 1'b0);
		add_entry(1, mem_pkg::REQ_WRITE, a1, $urandom, 4'b1000, 1'b0);
		add_entry(1, mem_pkg::REQ_READ, a1, 32'h0, 4'h0, 1'b0);
		// port 0 is served first when both ports request together
		add_entry(0, mem_pkg::REQ_READ, a1, 32'h0, 4'h0, 1'b1);
		add_entry(1, mem_pkg::REQ_WRITE, a0, $urandom, 4'hf, 1'b0);
		add_entry(0, mem_pkg::REQ_WRITE, a2, $urandom, 4'b0011, 1'b1);
		add_entry(1, mem_pkg::REQ_READ, a2, 32'h0, 4'h0, 1'b0);
		add_entry(1, mem_pkg::REQ_READ, a0, 32'h0, 4'h0, 1'b0);
	endtask

	task automatic send_byte(input logic [7:0] value);
		@(posedge clk);
		rx <= 1'b0;
		repeat (BIT_CYCLES - 1) @(posedge clk);
		for (int b = 0; b < 8; b++)
		begin
			@(posedge clk);
			rx <= value[b];
			repeat (BIT_CYCLES - 1) @(posedge clk);
		end
		@(posedge clk);
		rx <= 1'b1;
		repeat (BIT_CYCLES - 1) @(posedge clk);
	endtask

	task automatic send_frame(input logic [2:0] chan, input logic [4:0] len,
		input logic [`MESSAGE_BIT-1:0] data);
		send_byte({chan, len});
		for (int k = 0; k < int'(len); k++)
			send_byte(data[k*8 +: 8]);
	endtask

	// tx is sampled on falling edges near mid-bit
	task automatic recv_byte(input int limit, output logic [7:0] value, output logic ok);
		int cycles;
		cycles = 0;
		value = 8'h00;
		ok = 1'b0;
		@(negedge clk);
		while (tx !== 1'b0 && cycles < limit)
		begin
			@(negedge clk);
			cycles++;
		end
		if (tx !== 1'b0)
		begin
			$display("host model saw no start bit on tx within %0d cycles", limit);
			n_timeout++;
		end
		else
		begin
			repeat (BIT_CYCLES / 2) @(negedge clk);
			for (int b = 0; b < 8; b++)
			begin
				repeat (BIT_CYCLES) @(negedge clk);
				value[b] = tx;
			end
			repeat (BIT_CYCLES) @(negedge clk);
			ok = (tx === 1'b1);
			if (!ok)
			begin
				$display("FAIL %0t: host model saw a byte without a stop bit", $time);
				n_fail++;
			end
		end
	endtask

	task automatic handle_request(input int len, input logic [`MESSAGE_BIT-1:0] buffer);
		logic [3:0] op;
		logic [31:0] addr;
		logic [31:0] old_word;
		op = buffer[7:4];
		addr = buffer[39:8];
		old_word = host_mem.exists(addr) ? host_mem[addr] : fill_word(addr);
		if (op == mem_pkg::OP_READ && len == 5)
			send_frame(3'd0, 5'd4, {40'd0, old_word});
		else if (op == mem_pkg::OP_WRITE && len == 9)
		begin
			host_mem[addr] = merge_bytes(old_word, buffer[71:40], buffer[3:0]);
			send_frame(3'd0, 5'd1, {64'd0, mem_pkg::OP_ACK, 4'h0});
		end
		else
		begin
			$display("FAIL %0t: host model got opcode %0d with length %0d",
				$time, op, len);
			n_fail++;
		end
	endtask

	task automatic serve_host();
		logic [7:0] hdr;
		logic [7:0] value;
		logic ok;
		logic [`MESSAGE_BIT-1:0] buffer;
		int len;
		recv_byte(IDLE_LIMIT, hdr, ok);
		len = int'(hdr[4:0]);
		buffer = '0;
		for (int k = 0; k < len && ok; k++)
		begin
			recv_byte(BYTE_LIMIT, value, ok);
			if (k < `MESSAGE_BIT / 8)
				buffer[k*8 +: 8] = value;
		end
		if (ok && len > `MESSAGE_BIT / 8)
		begin
			$display("FAIL %0t: host model got a frame of %0d bytes", $time, len);
			n_fail++;
		end
		else if (ok && hdr[7:5] == 3'd0)
			handle_request(len, buffer);
		else if (ok && hdr[7:5] == 3'd1)
		begin
			host_aux_data.push_back(buffer);
			host_aux_len.push_back(len);
		end
		else if (ok)
		begin
			$display("FAIL %0t: host model got a frame for channel %0d", $time, hdr[7:5]);
			n_fail++;
		end
	endtask

	initial
	begin
		forever
			serve_host();
	end

	// done checks and aux receive capture
	always @(negedge clk)
	begin
		if (button)
		begin
			for (int p = 0; p < 2; p++)
			begin
				if (mem_done[p])
				begin
					done_order.push_back(p);
					n_checks++;
					if (!busy_prev[p])
					begin
						$display("FAIL %0t: done on port %0d without busy before", $time, p);
						n_fail++;
					end
				end
			end
			if (aux_r_flag)
			begin
				aux_pulses++;
				aux_seen_data = aux_r_data;
				aux_seen_len = aux_r_length;
			end
		end
		busy_prev = mem_busy;
	end

	task automatic drive_request(input int i);
		mem_rw_flag[2*t_port[i] +: 2] <= t_req[i];
		mem_addr[32*t_port[i] +: 32] <= t_addr[i];
		mem_w_data[32*t_port[i] +: 32] <= t_data[i];
		mem_w_mask[4*t_port[i] +: 4] <= t_mask[i];
	endtask

	task automatic wait_done(input int i);
		int cycles;
		int p;
		logic [31:0] got;
		p = t_port[i];
		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
		end
		while (!mem_done[p] && cycles < DONE_LIMIT);
		if (!mem_done[p])
		begin
			$display("timeout waiting for mem_done on port %0d, entry %0d", p, i);
			n_timeout++;
		end
		else if (t_req[i] == mem_pkg::REQ_READ)
		begin
			got = mem_r_data[32*p +: 32];
			n_checks++;
			if (got !== t_expect[i])
			begin
				$display("FAIL %0t: entry %0d port %0d read %h, expected %h",
					$time, i, p, got, t_expect[i]);
				n_fail++;
			end
		end
		// drop the request right after done
		@(posedge clk);
		mem_rw_flag[2*p +: 2] <= mem_pkg::REQ_NONE;
	endtask

	initial
	begin
		int seed;
		int i;
		int cycles;
		logic [`MESSAGE_BIT-1:0] aux_data;
		button = 1'b0;
		rx = 1'b1;
		mem_rw_flag = '0;
		mem_addr = '0;
		mem_w_data = '0;
		mem_w_mask = '0;
		aux_w_flag = 1'b0;
		aux_w_data = '0;
		aux_w_length = '0;
		n_checks = 0;
		n_fail = 0;
		n_timeout = 0;
		aux_pulses = 0;
		busy_prev = 2'b00;
		seed = $urandom(69);
		build_table();
		repeat (16) @(posedge clk);
		button <= 1'b1;
		@(negedge clk);
		n_checks++;
		if (tx !== 1'b1 || mem_busy !== 2'b00 || mem_done !== 2'b00 || aux_writable !== 1'b1)
		begin
			$display("FAIL %0t: idle state after reset is wrong", $time);
			n_fail++;
		end

		i = 0;
		while (i < t_count)
		begin
			done_order.delete();
			@(posedge clk);
			drive_request(i);
			if (t_pair[i])
			begin
				drive_request(i + 1);
				wait_done(i);
				wait_done(i + 1);
				n_checks++;
				if (done_order.size() != 2 || done_order[0] != 0 || done_order[1] != 1)
				begin
					$display("FAIL %0t: entries %0d and %0d did not finish port 0 first",
						$time, i, i + 1);
					n_fail++;
				end
				i += 2;
			end
			else
			begin
				wait_done(i);
				i++;
			end
		end

		// channel 1 toward the host
		aux_data = {8'($urandom), $urandom, $urandom};
		cycles = 0;
		@(negedge clk);
		while (!aux_writable && cycles < DONE_LIMIT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!aux_writable)
		begin
			$display("timeout waiting for aux_writable");
			n_timeout++;
		end
		@(posedge clk);
		aux_w_flag <= 1'b1;
		aux_w_data <= aux_data;
		aux_w_length <= 5'd6;
		@(posedge clk);
		aux_w_flag <= 1'b0;
		cycles = 0;
		while (host_aux_data.size() == 0 && cycles < DONE_LIMIT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (host_aux_data.size() == 0)
		begin
			$display("timeout waiting for the channel 1 frame at the host model");
			n_timeout++;
		end
		else
		begin
			n_checks++;
			if (host_aux_len[0] != 6 || host_aux_data[0] !== keep_bytes(aux_data, 5'd6))
			begin
				$display("FAIL %0t: host got %0d bytes %h on channel 1", $time,
					host_aux_len[0], host_aux_data[0]);
				n_fail++;
			end
		end

		// channel 1 from the host
		aux_data = keep_bytes({8'($urandom), $urandom, $urandom}, 5'd5);
		aux_pulses = 0;
		send_frame(3'd1, 5'd5, aux_data);
		cycles = 0;
		while (aux_pulses == 0 && cycles < DONE_LIMIT)
		begin
			@(negedge clk);
			cycles++;
		end
		// window for a stray second pulse
		repeat (4 * BIT_CYCLES) @(negedge clk);
		if (aux_pulses == 0)
		begin
			$display("timeout waiting for aux_r_flag");
			n_timeout++;
		end
		else
		begin
			n_checks++;
			if (aux_pulses != 1 || aux_seen_len !== 5'd5 || aux_seen_data !== aux_data)
			begin
				$display("FAIL %0t: aux_r_flag x%0d with %0d bytes %h", $time,
					aux_pulses, aux_seen_len, aux_seen_data);
				n_fail++;
			end
		end

		$display("checks %0d, failures %0d, timeouts %0d", n_checks, n_fail, n_timeout);
		if (n_fail == 0 && n_timeout == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* list.f */
+incdir+include
source/link_pkg.sv
source/mem_pkg.sv
source/uart_comm.sv
source/multchan_comm.sv
source/memory_controller.sv
source/link_top.sv
sim/link_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := link_tb
FILE_LIST  := list.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_TEXT  := Finished with no errors
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
